//--- spriteAffine.f
source/spriteAffinePkg.sv
source/oamMemory.sv
source/attributeLookupUnit.sv
source/affineStepper.sv
source/creditOutput.sv
source/spriteAffineTop.sv
verif/spriteAffineTb.sv

//--- verif/spriteAffineVectors.txt
# W index data | R group x0 y0 length | E texX texY last
# All fields hex; offsets and coordinates are two's complement.
W 00 01001234
W 01 00005678
W 02 00009abc
W 03 0100def0
W 04 00801111
W 05 ff802222
W 06 00803333
W 07 00804444
R 00 fd 02 05
E fffd 0002 0
E fffe 0002 0
E ffff 0002 0
E 0000 0002 0
E 0001 0002 1
R 01 02 03 02
E 0003 ffff 0
E 0003 0000 1
R 02 fd 01 04
E fffe ffff 0
E fffe ffff 0
E ffff 0000 0
E ffff 0000 1
W 00 02001234
R 00 f8 fb 10
E fff0 fffb 0
E fff2 fffb 0
E fff4 fffb 0
E fff6 fffb 0
E fff8 fffb 0
E fffa fffb 0
E fffc fffb 0
E fffe fffb 0
E 0000 fffb 0
E 0002 fffb 0
E 0004 fffb 0
E 0006 fffb 0
E 0008 fffb 0
E 000a fffb 0
E 000c fffb 0
E 000e fffb 1

//--- verif/spriteAffineTb.sv
`default_nettype none

module spriteAffineTb
    import spriteAffinePkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int QUEUE_DEPTH = 8;
    localparam int CREDITS = 4;
    localparam int TIMEOUT = 2000; // In clock cycles.

    logic clock = 1'b0;
    logic reset = 1'b1;
    logic oamWrite, reqValid, reqReady, outValid, outLast, creditReturn;
    oamWordIndex_t oamWriteIndex;
    oamWord_t oamWriteData;
    groupIndex_t reqGroup;
    pixelOffset_t reqX, reqY;
    runLength_t reqLength;
    texCoord_t outTexX, outTexY;

    logic [15:0] expectX [$];
    logic [15:0] expectY [$];
    logic expectLast [$];
    int releaseAt [$]; // Cycle in which each occupied consumer slot frees up.
    integer seed;
    int cycle, transfers, returned;

    spriteAffineTop #(
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .CREDITS(CREDITS)
    ) DUT (.*);

    always #20 clock = ~clock;

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check(input logic [15:0] actual, input logic [15:0] expected,
                         input string what);
        if (actual !== expected) begin
            failRun($sformatf("FAIL at %0t ns: %s is %h, expected %h",
                              $time, what, actual, expected));
        end
    endtask

    task automatic waitReady();
        int waited;
        waited = 0;
        while (!reqReady) begin
            @(posedge clock);
            #2;
            waited++;
            if (waited > TIMEOUT) failRun("Timed out waiting for reqReady.");
        end
    endtask

    task automatic writeWord(input logic [31:0] index, input logic [31:0] data);
        waitReady(); // No lookup may be reading the OAM.
        oamWrite = 1'b1;
        oamWriteIndex = index[5:0];
        oamWriteData = data;
        @(posedge clock);
        #2;
        oamWrite = 1'b0;
    endtask

    task automatic sendRequest(input logic [31:0] g, x, y, len);
        waitReady();
        reqValid = 1'b1;
        reqGroup = g[4:0];
        reqX = x[7:0];
        reqY = y[7:0];
        reqLength = len[7:0];
        @(posedge clock);
        #2;
        reqValid = 1'b0;
    endtask

    // Consumer buffer. Frees one slot per cycle once its delay has run out.
    always @(posedge clock) begin
        cycle++;
        #2;
        if (releaseAt.size() != 0 && releaseAt[0] <= cycle) begin
            releaseAt.delete(0);
            creditReturn = 1'b1;
            returned++;
        end else begin
            creditReturn = 1'b0;
        end
    end

    // Outputs are stable at the falling edge; the transfer completes at the next rising one.
    always @(negedge clock) begin
        if (!reset && outValid) begin
            if (expectX.size() == 0) failRun("An output arrived that no vector expects.");
            check(outTexX, expectX.pop_front(), "texX");
            check(outTexY, expectY.pop_front(), "texY");
            check(outLast, expectLast.pop_front(), "outLast");
            transfers++;
            // A credit returned in this cycle only becomes usable in the next one.
            check(transfers <= returned - int'(creditReturn) + CREDITS, 1'b1,
                  "output within returned credits");
            releaseAt.push_back(cycle + 1 + ($unsigned($random(seed)) % 6));
        end
    end

    initial begin
        int fd;
        int waited;
        string line;
        byte kind;
        logic [31:0] a, b, c, d;
        seed = 32'ha605a0e0;
        cycle = 0;
        transfers = 0;
        returned = 0;
        oamWrite = 1'b0;
        oamWriteIndex = '0;
        oamWriteData = '0;
        reqValid = 1'b0;
        reqGroup = '0;
        reqX = '0;
        reqY = '0;
        reqLength = '0;
        creditReturn = 1'b0;
        repeat (10) @(posedge clock);
        #2;
        reset = 1'b0;
        check(outValid, 1'b0, "outValid after reset");
        check(reqReady, 1'b1, "reqReady after reset");

        fd = $fopen("verif/spriteAffineVectors.txt", "r");
        if (fd == 0) failRun("Could not open the vector file.");
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
                void'($sscanf(line, "%c %h %h %h %h", kind, a, b, c, d));
                case (kind)
                    "W": writeWord(a, b);
                    "R": sendRequest(a, b, c, d);
                    "E": begin
                        expectX.push_back(a[15:0]);
                        expectY.push_back(b[15:0]);
                        expectLast.push_back(c[0]);
                    end
                    default: failRun("The vector file holds a line of unknown kind.");
                endcase
            end
        end
        $fclose(fd);

        waited = 0;
        while (expectX.size() != 0) begin
            @(posedge clock);
            waited++;
            if (waited > TIMEOUT) failRun("Timed out waiting for the remaining outputs.");
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule : spriteAffineTb

`default_nettype wire

//--- source/spriteAffineTop.sv
`default_nettype none

module spriteAffineTop
    import spriteAffinePkg::*;
#(
    parameter int QUEUE_DEPTH = 8,
    parameter int CREDITS = 4 // Size of the consumer's buffer.
) (
    input  logic          clock,
    input  logic          reset,
    input  logic          oamWrite,
    input  oamWordIndex_t oamWriteIndex,
    input  oamWord_t      oamWriteData,
    input  logic          reqValid,
    input  groupIndex_t   reqGroup,
    input  pixelOffset_t  reqX,
    input  pixelOffset_t  reqY,
    input  runLength_t    reqLength,
    output logic          reqReady,
    output logic          outValid,
    output texCoord_t     outTexX,
    output texCoord_t     outTexY,
    output logic          outLast,
    input  logic          creditReturn
);

    logic start, done, read, push, pushLast, space;
    groupIndex_t group;
    oamByteAddr_t readAddr;
    oamWord_t readData;
    affineParam_t paramA, paramB, paramC, paramD;
    texCoord_t pushTexX, pushTexY;

    oamMemory oam (
        .clock, .reset, .oamWrite, .oamWriteIndex, .oamWriteData,
        .read, .readAddr, .readData
    );

    attributeLookupUnit lookup (
        .clock, .reset, .start, .group, .readData, .readAddr, .read, .done,
        .paramA, .paramB, .paramC, .paramD
    );

    affineStepper stepper (
        .clock, .reset, .reqValid, .reqGroup, .reqX, .reqY, .reqLength,
        .done, .paramA, .paramB, .paramC, .paramD, .space,
        .reqReady, .start, .group, .push, .pushTexX, .pushTexY, .pushLast
    );

    creditOutput #(
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .CREDITS(CREDITS)
    ) outQueue (
        .clock, .reset, .push, .pushTexX, .pushTexY, .pushLast, .creditReturn,
        .space, .outValid, .outTexX, .outTexY, .outLast
    );

endmodule : spriteAffineTop

`default_nettype wire

//--- source/creditOutput.sv
`default_nettype none

module creditOutput
    import spriteAffinePkg::*;
#(
    parameter int QUEUE_DEPTH = 8,
    parameter int CREDITS = 4
) (
    input  logic      clock,
    input  logic      reset,
    input  logic      push,
    input  texCoord_t pushTexX,
    input  texCoord_t pushTexY,
    input  logic      pushLast,
    input  logic      creditReturn,
    output logic      space,
    output logic      outValid,
    output texCoord_t outTexX,
    output texCoord_t outTexY,
    output logic      outLast
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int COUNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam int CREDIT_W = $clog2(CREDITS + 1);

    texCoord_t queueX [QUEUE_DEPTH];
    texCoord_t queueY [QUEUE_DEPTH];
    logic queueLast [QUEUE_DEPTH];

    logic [PTR_W-1:0] head, tail;
    logic [COUNT_W-1:0] count;
    logic [CREDIT_W-1:0] credits;

    assign space = (count != COUNT_W'(QUEUE_DEPTH));
    assign outValid = (count != '0) && (credits != '0); // The head leaves whenever it may.
    assign outTexX = queueX[head];
    assign outTexY = queueY[head];
    assign outLast = outValid && queueLast[head];

    always_ff @(posedge clock) begin
        if (push) begin
            queueX[tail] <= pushTexX;
            queueY[tail] <= pushTexY;
            queueLast[tail] <= pushLast;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            credits <= CREDIT_W'(CREDITS);
        end else begin
            if (push) begin
                tail <= (tail == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (outValid) begin
                head <= (head == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : head + 1'b1;
            end
            count <= count + COUNT_W'(push) - COUNT_W'(outValid);
            credits <= credits + CREDIT_W'(creditReturn) - CREDIT_W'(outValid);
        end
    end

    creditBound: assert property (
        @(posedge clock) disable iff (reset)
        credits <= CREDIT_W'(CREDITS)
    ) else $error("Consumer returned more credits than its buffer holds.");

    noPushWhenFull: assert property (
        @(posedge clock) disable iff (reset)
        push |-> space
    ) else $error("Push into a full output queue.");

endmodule : creditOutput

`default_nettype wire

//--- source/affineStepper.sv
`default_nettype none

module affineStepper
    import spriteAffinePkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         reqValid,
    input  groupIndex_t  reqGroup,
    input  pixelOffset_t reqX,
    input  pixelOffset_t reqY,
    input  runLength_t   reqLength,
    input  logic         done,
    input  affineParam_t paramA,
    input  affineParam_t paramB,
    input  affineParam_t paramC,
    input  affineParam_t paramD,
    input  logic         space,
    output logic         reqReady,
    output logic         start,
    output groupIndex_t  group,
    output logic         push,
    output texCoord_t    pushTexX,
    output texCoord_t    pushTexY,
    output logic         pushLast
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_LOOKUP,
        INIT_SUMS,
        RUN
    } stepState_t;

    stepState_t state;

    pixelOffset_t x0, y0;
    runLength_t remaining;
    logic signed [31:0] sumX, sumY;
    logic signed [31:0] startX, startY;

    assign reqReady = (state == IDLE);
    assign start = reqValid && reqReady;
    assign group = reqGroup; // Sampled by the lookup only while start is high.

    // Both operands are signed, so they extend to the 32-bit result width.
    assign startX = paramA * x0 + paramB * y0;
    assign startY = paramC * x0 + paramD * y0;

    assign push = (state == RUN) && space;
    assign pushTexX = texCoord_t'(sumX >>> FRACTION_BITS);
    assign pushTexY = texCoord_t'(sumY >>> FRACTION_BITS);
    assign pushLast = (remaining == '0);

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state <= IDLE;
            remaining <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        remaining <= reqLength - 8'd1; // Zero wraps to 255, i.e. 256 pixels.
                        state <= WAIT_LOOKUP;
                    end
                end
                WAIT_LOOKUP: if (done) state <= INIT_SUMS;
                INIT_SUMS: state <= RUN;
                RUN: begin
                    if (push) begin
                        if (pushLast) state <= IDLE;
                        else remaining <= remaining - 8'd1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Accumulators hold while the queue is full.
    always_ff @(posedge clock) begin
        if (start) begin
            x0 <= reqX;
            y0 <= reqY;
        end
        if (state == INIT_SUMS) begin
            sumX <= startX;
            sumY <= startY;
        end else if (push) begin
            sumX <= sumX + paramA;
            sumY <= sumY + paramC;
        end
    end

    doneWhileWaiting: assert property (
        @(posedge clock) disable iff (reset)
        done |-> (state == WAIT_LOOKUP)
    ) else $error("Lookup finished while no request was waiting for it.");

endmodule : affineStepper

`default_nettype wire

//--- source/attributeLookupUnit.sv
`default_nettype none

module attributeLookupUnit
    import spriteAffinePkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         start,
    input  groupIndex_t  group,
    input  oamWord_t     readData,
    output oamByteAddr_t readAddr,
    output logic         read,
    output logic         done,
    output affineParam_t paramA,
    output affineParam_t paramB,
    output affineParam_t paramC,
    output affineParam_t paramD
);

    typedef enum logic [2:0] {
        IDLE,
        CAPTURE_A,
        CAPTURE_B,
        CAPTURE_C,
        CAPTURE_D,
        FINISH
    } lookupState_t;

    lookupState_t state, nextState;

    oamByteAddr_t addrReg;

    // Group n starts at byte 8n, so neighbouring groups share two words.
    assign readAddr = (state == IDLE) ? {group, 3'b000} : addrReg;

    always_comb begin
        read = 1'b0;
        done = 1'b0;
        nextState = state;
        case (state)
            IDLE: begin
                read = start;
                if (start) begin
                    nextState = CAPTURE_A;
                end
            end
            CAPTURE_A: begin
                read = 1'b1;
                nextState = CAPTURE_B;
            end
            CAPTURE_B: begin
                read = 1'b1;
                nextState = CAPTURE_C;
            end
            CAPTURE_C: begin
                read = 1'b1;
                nextState = CAPTURE_D;
            end
            CAPTURE_D: nextState = FINISH;
            FINISH: begin
                done = 1'b1;
                nextState = IDLE;
            end
            default: nextState = IDLE;
        endcase
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    // Next word address, one cycle behind the address on the bus.
    always_ff @(posedge clock) begin
        addrReg <= readAddr + 8'd4;
        case (state)
            CAPTURE_A: paramA <= readData[31:16];
            CAPTURE_B: paramB <= readData[31:16];
            CAPTURE_C: paramC <= readData[31:16];
            CAPTURE_D: paramD <= readData[31:16];
            default: ;
        endcase
    end

    startWhenIdle: assert property (
        @(posedge clock) disable iff (reset)
        start |-> (state == IDLE)
    ) else $error("Lookup started while a fetch was still running.");

endmodule : attributeLookupUnit

`default_nettype wire

//--- source/oamMemory.sv
`default_nettype none

module oamMemory
    import spriteAffinePkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  logic          oamWrite,
    input  oamWordIndex_t oamWriteIndex,
    input  oamWord_t      oamWriteData,
    input  logic          read,
    input  oamByteAddr_t  readAddr,
    output oamWord_t      readData
);

    oamWord_t memory [64];

    oamWordIndex_t readIndex;

    assign readIndex = readAddr[7:2]; // Byte address to word index.

    always_ff @(posedge clock) begin
        if (oamWrite) begin
            memory[oamWriteIndex] <= oamWriteData;
        end
    end

    // Read data holds between reads so the lookup may sample it late.
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            readData <= '0;
        end else if (read) begin
            readData <= memory[readIndex];
        end
    end

    // The lookup only ever steps in whole words.
    readAligned: assert property (
        @(posedge clock) disable iff (reset)
        read |-> (readAddr[1:0] == 2'b00)
    ) else $error("OAM read at unaligned byte address %0h.", readAddr);

endmodule : oamMemory

`default_nettype wire

//--- source/spriteAffinePkg.sv
`default_nettype none

package spriteAffinePkg;

    // OAM addressing as seen by the host and by the lookup.
    typedef logic [7:0] oamByteAddr_t;
    typedef logic [5:0] oamWordIndex_t;
    typedef logic [31:0] oamWord_t;

    // Parameters are 8.8 fixed point and live in the upper halfword of a word.
    typedef logic signed [15:0] affineParam_t;

    typedef logic [4:0] groupIndex_t;

    typedef logic signed [7:0] pixelOffset_t; // Relative to the sprite centre.

    // A length of zero stands for a full run of 256 pixels.
    typedef logic [7:0] runLength_t;

    // Integer part of the 32-bit accumulator.
    typedef logic signed [15:0] texCoord_t;

    localparam int FRACTION_BITS = 8;

endpackage : spriteAffinePkg

`default_nettype wire
